//--- verilog/fusion_consts.svh
/*
 * Fusion constants
 * Sample format, calibration offsets and complementary filter coefficients
 */

`ifndef FUSION_CONSTS_SVH
`define FUSION_CONSTS_SVH

// Width of raw samples, corrected samples and the angle
`define SAMPLE_WIDTH 10

// Per-axis calibration offsets, measured on the bench with the vehicle level
`define ACCEL_OFFSET 8
`define GYRO_OFFSET (-7)

// Gyro path weight in hundredths; the accelerometer path gets the remainder
`define FILTER_WEIGHT 94

// Leak applied to the previous angle each sample, in hundredths
`define ANGLE_DECAY 99

// Converts one period of gyro rate into angle units
`define GYRO_DIVISOR 3

// Common denominator of the weights
`define FILTER_SCALE 100

// Magnitude bound the vehicle controller expects on the output
`define ANGLE_LIMIT 255

`endif

//--- verilog/fusionPkg.sv
/*
 * Fusion types
 * Sample, angle and filter accumulator types shared by the pipeline stages
 */

`include "fusion_consts.svh"

package fusionPkg;

	// One signed axis sample as delivered by the IMU
	typedef logic signed [`SAMPLE_WIDTH-1:0] sample_t;

	// Tilt angle, same width as a sample
	typedef logic signed [`SAMPLE_WIDTH-1:0] angle_t;

	// Intermediate for the blend arithmetic
	// 24 bits leaves headroom over the largest weighted product
	typedef logic signed [23:0] filterAcc_t;

endpackage

//--- verilog/sampleCapture.sv
/*
 * Sample capture stage
 * Registers the raw accelerometer and gyro pair and starts the valid bit
 */

`timescale 1ns/1ps

module sampleCapture
	import fusionPkg::*;
(
	// Sample strobe from the IMU, used as the pipeline clock
	input  logic    DataReady,
	input  logic    rst,
	input  sample_t Accel,
	input  sample_t Gyro,
	output sample_t rawAccel,
	output sample_t rawGyro,
	output logic    captureValid
);

	// Both axes are sampled together so they stay aligned through the pipeline
	always_ff @(posedge DataReady) begin
		if (rst) begin
			rawAccel <= '0;
			rawGyro  <= '0;
		end else begin
			rawAccel <= Accel;
			rawGyro  <= Gyro;
		end
	end

	// The first edge out of reset carries the first real pair
	// After that every edge is a sample, so the bit just stays set
	always_ff @(posedge DataReady) begin
		if (rst) begin
			captureValid <= 1'b0;
		end else begin
			captureValid <= 1'b1;
		end
	end

endmodule

//--- verilog/offsetCorrect.sv
/*
 * Offset correction stage
 * Adds a calibration offset to one axis and saturates to the sample range
 */

`timescale 1ns/1ps

module offsetCorrect
	import fusionPkg::*;
#(
	// Calibration offset for this axis
	parameter int Offset = 0
) (
	input  logic    DataReady,
	input  logic    rst,
	input  sample_t sampleIn,
	input  logic    validIn,
	output sample_t sampleOut,
	output logic    validOut
);

	// Range of a signed sample
	localparam int SampleMax = 2 ** ($bits(sample_t) - 1) - 1;
	localparam int SampleMin = -(2 ** ($bits(sample_t) - 1));

	int      sumWide;
	sample_t satSample;

	// The sum is formed at integer width so an edge sample cannot wrap
	always_comb begin
		sumWide = int'(sampleIn) + Offset;
		if (sumWide > SampleMax) begin
			satSample = sample_t'(SampleMax);
		end else if (sumWide < SampleMin) begin
			satSample = sample_t'(SampleMin);
		end else begin
			satSample = sample_t'(sumWide);
		end
	end

	// Corrected sample and its valid bit advance together
	always_ff @(posedge DataReady) begin
		if (rst) begin
			sampleOut <= '0;
			validOut  <= 1'b0;
		end else begin
			sampleOut <= satSample;
			validOut  <= validIn;
		end
	end

endmodule

//--- verilog/complementaryFilter.sv
/*
 * Complementary filter
 * Blends the integrated gyro rate with the accelerometer angle
 * and holds the resulting tilt angle as its state
 */

`timescale 1ns/1ps

`include "fusion_consts.svh"

module complementaryFilter
	import fusionPkg::*;
(
	input  logic    DataReady,
	input  logic    rst,
	input  sample_t corrAccel,
	input  sample_t corrGyro,
	input  logic    validIn,
	output angle_t  filterAngle,
	output logic    filterValid
);

	// Coefficients at accumulator width so the arithmetic stays signed and 24 bits
	localparam filterAcc_t GyroWeight  = `FILTER_WEIGHT;
	localparam filterAcc_t AccelWeight = `FILTER_SCALE - `FILTER_WEIGHT;
	localparam filterAcc_t Decay       = `ANGLE_DECAY;
	localparam filterAcc_t GyroDivisor = `GYRO_DIVISOR;
	localparam filterAcc_t Scale       = `FILTER_SCALE;

	// Saturation bounds of the angle state
	localparam filterAcc_t AngleMax = 2 ** (`SAMPLE_WIDTH - 1) - 1;
	localparam filterAcc_t AngleMin = -(2 ** (`SAMPLE_WIDTH - 1));

	filterAcc_t gyroStep;
	filterAcc_t decayedAngle;
	filterAcc_t gyroPath;
	filterAcc_t weightedGyro;
	filterAcc_t weightedAccel;
	filterAcc_t blendSum;
	filterAcc_t blendAngle;
	angle_t     angleNext;

	// All divisions truncate toward zero, matching the signed divide in SV
	always_comb begin
		// Rate over one sample period becomes an angle step
		gyroStep = filterAcc_t'(corrGyro) / GyroDivisor;

		// Previous angle leaks slightly so gyro drift does not accumulate
		decayedAngle = filterAcc_t'(filterAngle) * Decay;

		// Gyro estimate of the new angle, back in angle units
		gyroPath = (decayedAngle - gyroStep) / Scale;

		// Weighted blend; the accelerometer pulls the estimate toward gravity
		weightedGyro  = GyroWeight * gyroPath;
		weightedAccel = filterAcc_t'(corrAccel) * AccelWeight;
		blendSum      = weightedGyro + weightedAccel;
		blendAngle    = blendSum / Scale;

		// Clamp to the signed sample range before it goes back into the state
		if (blendAngle > AngleMax) begin
			angleNext = angle_t'(AngleMax);
		end else if (blendAngle < AngleMin) begin
			angleNext = angle_t'(AngleMin);
		end else begin
			angleNext = angle_t'(blendAngle);
		end
	end

	// State moves only on real samples, so the empty slots
	// behind reset never disturb the starting angle of zero
	always_ff @(posedge DataReady) begin
		if (rst) begin
			filterAngle <= '0;
		end else if (validIn) begin
			filterAngle <= angleNext;
		end
	end

	// Valid follows the input by one edge, same as the state
	always_ff @(posedge DataReady) begin
		if (rst) begin
			filterValid <= 1'b0;
		end else begin
			filterValid <= validIn;
		end
	end

endmodule

//--- verilog/angleLimiter.sv
/*
 * Angle limiter
 * Clamps the filtered angle to the published output range and registers it
 */

`timescale 1ns/1ps

`include "fusion_consts.svh"

module angleLimiter
	import fusionPkg::*;
(
	input  logic   DataReady,
	input  logic   rst,
	input  angle_t filterAngle,
	input  logic   filterValid,
	output angle_t ResolvedAngle,
	output logic   AngleValid
);

	// The controller downstream is tuned for a symmetric range
	localparam angle_t LimitPos = angle_t'(`ANGLE_LIMIT);
	localparam angle_t LimitNeg = angle_t'(-`ANGLE_LIMIT);

	angle_t clampedAngle;

	// The filter state may run out to the full sample range; only the output is bounded
	always_comb begin
		if (filterAngle > LimitPos) begin
			clampedAngle = LimitPos;
		end else if (filterAngle < LimitNeg) begin
			clampedAngle = LimitNeg;
		end else begin
			clampedAngle = filterAngle;
		end
	end

	// Output register, last stage of the pipeline
	always_ff @(posedge DataReady) begin
		if (rst) begin
			ResolvedAngle <= '0;
			AngleValid    <= 1'b0;
		end else begin
			ResolvedAngle <= clampedAngle;
			AngleValid    <= filterValid;
		end
	end

endmodule

//--- verilog/sensorFusionTop.sv
/*
 * Sensor fusion top
 * Capture, offset correction, complementary filter and limiter in one pipeline
 */

`timescale 1ns/1ps

`include "fusion_consts.svh"

module sensorFusionTop
	import fusionPkg::*;
(
	input  logic    DataReady,
	input  logic    rst,
	input  sample_t Accel,
	input  sample_t Gyro,
	output angle_t  ResolvedAngle,
	output logic    AngleValid
);

	sample_t rawAccel;
	sample_t rawGyro;
	logic    captureValid;
	sample_t corrAccel;
	sample_t corrGyro;
	logic    corrValid;
	angle_t  filterAngle;
	logic    filterValid;

	// Stage 1, raw pair registered on the strobe
	sampleCapture capture (
		.DataReady    (DataReady),
		.rst          (rst),
		.Accel        (Accel),
		.Gyro         (Gyro),
		.rawAccel     (rawAccel),
		.rawGyro      (rawGyro),
		.captureValid (captureValid)
	);

	// Stage 2, per-axis calibration
	// Both instances see the same valid, so only the gyro copy is forwarded
	offsetCorrect #(.Offset(`ACCEL_OFFSET)) accelOffset (
		.DataReady (DataReady),
		.rst       (rst),
		.sampleIn  (rawAccel),
		.validIn   (captureValid),
		.sampleOut (corrAccel),
		.validOut  ()
	);

	offsetCorrect #(.Offset(`GYRO_OFFSET)) gyroOffset (
		.DataReady (DataReady),
		.rst       (rst),
		.sampleIn  (rawGyro),
		.validIn   (captureValid),
		.sampleOut (corrGyro),
		.validOut  (corrValid)
	);

	// Stage 3, angle state update
	complementaryFilter filter (
		.DataReady   (DataReady),
		.rst         (rst),
		.corrAccel   (corrAccel),
		.corrGyro    (corrGyro),
		.validIn     (corrValid),
		.filterAngle (filterAngle),
		.filterValid (filterValid)
	);

	// Stage 4, range clamp and output register
	angleLimiter limiter (
		.DataReady     (DataReady),
		.rst           (rst),
		.filterAngle   (filterAngle),
		.filterValid   (filterValid),
		.ResolvedAngle (ResolvedAngle),
		.AngleValid    (AngleValid)
	);

endmodule

//--- tb/sensorFusion_checker.sv
/*
 * Sensor fusion output checker
 * Concurrent assertions on reset, output range and valid timing of the top level
 */

`timescale 1ns/1ps

`include "fusion_consts.svh"

module sensorFusion_checker
	import fusionPkg::*;
(
	input logic   DataReady,
	input logic   rst,
	input angle_t ResolvedAngle,
	input logic   AngleValid
);

	// Count of failed assertions, watched by the testbench
	int failureCount = 0;

	// An edge with reset high leaves both outputs cleared
	resetClears: assert property (@(posedge DataReady)
		rst |=> (!AngleValid && ResolvedAngle == '0))
		else begin
			failureCount++;
			$error("Outputs were not cleared by a reset edge");
		end

	// The controller never sees an angle outside the published range
	rangeBound: assert property (@(posedge DataReady) disable iff (rst)
		(ResolvedAngle <= angle_t'(`ANGLE_LIMIT)) && (ResolvedAngle >= angle_t'(-`ANGLE_LIMIT)))
		else begin
			failureCount++;
			$error("ResolvedAngle left the range of plus or minus the angle limit");
		end

	// Once the stream is running only a reset may drop the valid level
	validHolds: assert property (@(posedge DataReady)
		(AngleValid && !rst) |=> AngleValid)
		else begin
			failureCount++;
			$error("AngleValid fell while reset was low");
		end

	// Three register stages sit between the capture edge and the output
	// so valid is seen low for three edges after release and high on the fourth
	validRise: assert property (@(posedge DataReady) disable iff (rst)
		$fell(rst) |=> !AngleValid ##1 !AngleValid ##1 !AngleValid ##1 AngleValid)
		else begin
			failureCount++;
			$error("AngleValid did not rise three edges after reset release");
		end

endmodule

bind sensorFusionTop sensorFusion_checker fusionCheck (
	.DataReady     (DataReady),
	.rst           (rst),
	.ResolvedAngle (ResolvedAngle),
	.AngleValid    (AngleValid)
);

//--- tb/sensorFusionTb.sv
/*
 * Sensor fusion testbench
 * Runs reset, steady, saturation, limit and random phases through the pipeline
 * and compares each valid angle with a model of the filter rules
 */

`timescale 1ns/1ps

`include "fusion_consts.svh"

module sensorFusionTb
	import fusionPkg::*;
();

	// The phases use about 690 edges and the limit leaves some margin
	localparam int TimeoutEdges = 800;
	localparam int ResetCycles  = 16;
	localparam int RandomPairs  = 500;
	localparam int RandomSeed   = 29480;
	localparam int SampleMax    = 511;
	localparam int SampleMin    = -512;

	logic    DataReady = 1'b0;
	logic    rst;
	sample_t Accel;
	sample_t Gyro;
	angle_t  ResolvedAngle;
	logic    AngleValid;

	// Pairs captured by the DUT that have not reached the output yet
	int accelQ[$];
	int gyroQ[$];
	int modelState = 0;
	int edgeCount  = 0;

	sensorFusionTop dut (
		.DataReady     (DataReady),
		.rst           (rst),
		.Accel         (Accel),
		.Gyro          (Gyro),
		.ResolvedAngle (ResolvedAngle),
		.AngleValid    (AngleValid)
	);

	always #10 DataReady = ~DataReady;

	function automatic int clampTo(int value, int low, int high);
		if (value > high) begin
			return high;
		end else if (value < low) begin
			return low;
		end else begin
			return value;
		end
	endfunction

	// One state update from a raw pair calibrates both axes and then blends them
	// All divisions are integer divisions, so they truncate toward zero
	function automatic int nextAngle(int state, int accelRaw, int gyroRaw);
		int accelCorr;
		int gyroCorr;
		int gyroEstimate;
		int blend;
		accelCorr    = clampTo(accelRaw + `ACCEL_OFFSET, SampleMin, SampleMax);
		gyroCorr     = clampTo(gyroRaw + `GYRO_OFFSET, SampleMin, SampleMax);
		gyroEstimate = (state * `ANGLE_DECAY - gyroCorr / `GYRO_DIVISOR) / `FILTER_SCALE;
		blend = `FILTER_WEIGHT * gyroEstimate + accelCorr * (`FILTER_SCALE - `FILTER_WEIGHT);
		return clampTo(blend / `FILTER_SCALE, SampleMin, SampleMax);
	endfunction

	task automatic failRun(string reason);
		$display("%s", reason);
		$display("Simulation failed");
		$fatal(1, "Run stopped at %0t", $time);
	endtask

	task automatic reportMismatch(string signalName, int expected, int actual);
		$display("MISMATCH at %0t: %s expected %0d, actual %0d",
			$time, signalName, expected, actual);
		failRun("Output did not agree with the reference model");
	endtask

	// The pair goes out on this edge and is captured on the next one
	task automatic applyPair(int accelValue, int gyroValue);
		@(posedge DataReady);
		Accel <= sample_t'(accelValue);
		Gyro  <= sample_t'(gyroValue);
	endtask

	task automatic applyReset();
		@(posedge DataReady);
		rst <= 1'b1;
		repeat (ResetCycles) @(posedge DataReady);
		rst <= 1'b0;
	endtask

	// Keep feeding one pair until the first angle is published
	// Right after an edge AngleValid still holds its value from the edge before
	task automatic fillPipeline(int accelValue, int gyroValue);
		applyPair(accelValue, gyroValue);
		while (!AngleValid) begin
			applyPair(accelValue, gyroValue);
		end
	endtask

	// Called just after an edge, when the output and the model refer to the same sample
	task automatic checkClamped(int bound);
		limitHeld: assert (ResolvedAngle == bound) else begin
			reportMismatch("ResolvedAngle", bound, ResolvedAngle);
		end
		stateBeyond: assert ((bound > 0) ? (modelState > bound) : (modelState < bound)) else begin
			failRun("Model state did not run past the output limit during the limit phase");
		end
	endtask

	always @(posedge DataReady) begin
		edgeCount = edgeCount + 1;
		if (edgeCount >= TimeoutEdges) begin
			failRun("Timeout: the test sequence did not finish within the edge limit");
		end
	end

	// Every pair the DUT captures is recorded and a reset edge empties the pipeline
	always @(posedge DataReady) begin
		if (rst) begin
			accelQ.delete();
			gyroQ.delete();
			modelState = 0;
		end else begin
			accelQ.push_back(Accel);
			gyroQ.push_back(Gyro);
		end
	end

	// With three pairs still in flight, the oldest one is the angle on the output
	always @(negedge DataReady) begin : resolveCheck
		int expected;
		if (dut.fusionCheck.failureCount != 0) begin
			failRun("A concurrent assertion in the checker failed");
		end
		validCheck: assert (AngleValid == (accelQ.size() > 3)) else begin
			reportMismatch("AngleValid", accelQ.size() > 3, AngleValid);
		end
		if (accelQ.size() > 3) begin
			modelState = nextAngle(modelState, accelQ.pop_front(), gyroQ.pop_front());
			expected   = clampTo(modelState, -`ANGLE_LIMIT, `ANGLE_LIMIT);
			angleCheck: assert (ResolvedAngle == expected) else begin
				reportMismatch("ResolvedAngle", expected, ResolvedAngle);
			end
		end
	end

	initial begin
		int accelRand;
		int gyroRand;
		void'($urandom(RandomSeed));
		rst   = 1'b1;
		Accel = '0;
		Gyro  = '0;

		// Power-on reset is followed by a small tilt while the pipeline fills
		repeat (ResetCycles) @(posedge DataReady);
		rst <= 1'b0;
		fillPipeline(40, 20);

		// With zero corrected rate and a steady tilt the angle settles on its fixed point
		repeat (40) applyPair(100, -`GYRO_OFFSET);

		// Extreme samples on both axes make the offset stage clamp
		repeat (4) begin
			applyPair(SampleMax, SampleMax);
			applyPair(SampleMin, SampleMin);
			applyPair(SampleMax, SampleMin);
			applyPair(SampleMin, SampleMax);
		end

		// A strong negative rate drives the state above the output limit
		repeat (40) applyPair(SampleMax, SampleMin);
		checkClamped(`ANGLE_LIMIT);

		// The opposite rate drives it below the negative limit
		repeat (40) applyPair(SampleMin, SampleMax);
		checkClamped(-`ANGLE_LIMIT);

		// A random stream is interrupted by a reset halfway through
		repeat (RandomPairs / 2) begin
			accelRand = int'($urandom);
			gyroRand  = int'($urandom);
			applyPair(accelRand, gyroRand);
		end
		applyReset();
		fillPipeline(-60, 35);
		repeat (RandomPairs / 2) begin
			accelRand = int'($urandom);
			gyroRand  = int'($urandom);
			applyPair(accelRand, gyroRand);
		end

		// The last pair is captured on the next edge and published three edges later
		// Two more edges let the negedge check and the checker see that output
		repeat (6) @(posedge DataReady);
		if (dut.fusionCheck.failureCount == 0) begin
			$display("Simulation completed successfully");
			$finish;
		end else begin
			failRun("A concurrent assertion in the checker failed");
		end
	end

endmodule

//--- list.f
+incdir+verilog
verilog/fusionPkg.sv
verilog/sampleCapture.sv
verilog/offsetCorrect.sv
verilog/complementaryFilter.sv
verilog/angleLimiter.sv
verilog/sensorFusionTop.sv
tb/sensorFusion_checker.sv
tb/sensorFusionTb.sv
